// ==== include/cpu16_config.svh ====
`ifndef CPU16_CONFIG_SVH
`define CPU16_CONFIG_SVH

// data and instruction word width
`define CPU_DATA_BITS 16

// one address past the real registers is kept for the discarded write
`define CPU_REG_ADDR_BITS 5

`define CPU_NUM_REGS 16

// register file drops writes to this address
`define CPU_NO_WRITE_ADDR 16

// upper immediate bits supplied by the 0x1 prefix
`define CPU_IMM_HI_BITS 12

`endif

// ==== source/cpu16_pkg.sv ====
`include "cpu16_config.svh"

package cpu16_pkg;

	typedef logic [`CPU_DATA_BITS-1:0] word_t;
	typedef logic [`CPU_REG_ADDR_BITS-1:0] reg_addr_t;
	typedef logic [4:0] alu_op_t;	// bit 4 set for single-register ops

	typedef struct packed {
		logic c;
		logic z;
		logic s;
	} flags_t;

	typedef enum logic [2:0] {
		COND_BZ, COND_BNZ, COND_BS, COND_BNS,
		COND_BC, COND_BNC, COND_BA, COND_RSVD
	} cond_t;

	localparam word_t NOP_INS = '0;

	// instruction field positions, each field one nibble wide
	localparam int OPC_LSB = 12;
	localparam int SUB_LSB = 8;	// also holds the branch condition
	localparam int DST_LSB = 4;
	localparam int SRC_LSB = 0;

	localparam logic [3:0] OPC_MISC   = 4'h0;
	localparam logic [3:0] OPC_IMM    = 4'h1;
	localparam logic [3:0] OPC_ALU_RR = 4'h2;
	localparam logic [3:0] OPC_ALU_RI = 4'h3;
	localparam logic [3:0] OPC_BRANCH = 4'h4;

	// sub-ops of the misc class
	localparam logic [3:0] MISC_INC    = 4'h2;
	localparam logic [3:0] MISC_DEC    = 4'h3;
	localparam logic [3:0] MISC_ALU_SR = 4'h4;

	function automatic logic [3:0] ins_class(input word_t ins);
		ins_class = ins[OPC_LSB +: 4];
	endfunction

	function automatic logic [3:0] ins_sub(input word_t ins);
		ins_sub = ins[SUB_LSB +: 4];
	endfunction

	function automatic reg_addr_t ins_dst(input word_t ins);
		ins_dst = reg_addr_t'(ins[DST_LSB +: 4]);
	endfunction

	function automatic reg_addr_t ins_src(input word_t ins);
		ins_src = reg_addr_t'(ins[SRC_LSB +: 4]);
	endfunction

	function automatic logic [3:0] ins_lo(input word_t ins);
		ins_lo = ins[SRC_LSB +: 4];
	endfunction

	function automatic logic [`CPU_IMM_HI_BITS-1:0] ins_imm_hi(input word_t ins);
		ins_imm_hi = ins[`CPU_IMM_HI_BITS-1:0];
	endfunction

	function automatic cond_t ins_cond(input word_t ins);
		ins_cond = cond_t'(ins[SUB_LSB +: 3]);
	endfunction

	function automatic alu_op_t alu_op_rr(input word_t ins);
		alu_op_rr = {1'b0, ins[SUB_LSB +: 4]};
	endfunction

	function automatic alu_op_t alu_op_sr(input word_t ins);
		alu_op_sr = {1'b1, ins[DST_LSB +: 4]};
	endfunction

	// inc, dec and single-register ops write back their source register
	function automatic logic writes_src(input word_t ins);
		writes_src = ins_class(ins) == OPC_MISC &&
			ins_sub(ins) inside {MISC_INC, MISC_DEC, MISC_ALU_SR};
	endfunction

	function automatic logic is_alu_op(input word_t ins);
		is_alu_op = ins_class(ins) inside {OPC_ALU_RR, OPC_ALU_RI} ||
			(ins_class(ins) == OPC_MISC && ins_sub(ins) == MISC_ALU_SR);
	endfunction

endpackage

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit (
	input  logic             CLK,
	input  logic             RSTb,
	input  cpu16_pkg::word_t mem_in,
	input  logic             stall,
	input  logic             stall_rewind,
	input  logic             redirect,
	input  cpu16_pkg::word_t redirect_target,
	output cpu16_pkg::word_t memory_addr,
	output cpu16_pkg::word_t stage1_ins
);
	import cpu16_pkg::*;

	word_t pc;
	word_t pc_prev;	// address of the word held in stage 1
	word_t pc_next;
	word_t pc_prev_next;
	word_t stage1_next;

	assign memory_addr = pc;

	always_comb begin
		pc_next = pc + word_t'(1);
		pc_prev_next = pc;
		stage1_next = mem_in;
		if (redirect) begin
			pc_next = redirect_target;
			stage1_next = NOP_INS;	// kill the word fetched behind the branch
		end else if (stall) begin
			stage1_next = stage1_ins;
			pc_prev_next = pc_prev;
			// a rewind refetches the held word, otherwise park one past it
			pc_next = stall_rewind ? pc_prev : pc_prev + word_t'(1);
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pc <= '0;
			pc_prev <= '0;
			stage1_ins <= NOP_INS;
		end else begin
			pc <= pc_next;
			pc_prev <= pc_prev_next;
			stage1_ins <= stage1_next;
		end
	end

endmodule

// ==== source/hazard_scoreboard.sv ====
`timescale 1ns/1ns
`include "cpu16_config.svh"

module hazard_scoreboard (
	input  logic                 CLK,
	input  logic                 RSTb,
	input  logic                 mark_valid,
	input  cpu16_pkg::reg_addr_t mark_reg,
	input  logic                 mark_flags,
	input  cpu16_pkg::reg_addr_t query_a,
	input  cpu16_pkg::reg_addr_t query_b,
	output logic                 busy,
	output logic                 clears_next,
	output logic                 flag_busy,
	output logic                 flag_clears_next
);
	import cpu16_pkg::*;

	localparam int IDX_BITS = $clog2(`CPU_NUM_REGS);

	typedef logic [`CPU_NUM_REGS-1:0] pend_t;

	pend_t mark_vec;
	pend_t pend2;
	pend_t pend3;
	pend_t pend4;
	pend_t pend_any;
	pend_t pend_early;	// still ahead of stage 4
	logic  flag2;
	logic  flag3;

	// addresses past the real registers never pend
	function automatic logic pend_bit(input pend_t vec, input reg_addr_t addr);
		pend_bit = 1'b0;
		if (addr < `CPU_NUM_REGS)
			pend_bit = vec[addr[IDX_BITS-1:0]];
	endfunction

	always_comb begin
		mark_vec = '0;
		if (mark_valid && mark_reg < `CPU_NUM_REGS)
			mark_vec[mark_reg[IDX_BITS-1:0]] = 1'b1;
	end

	assign pend_any = pend2 | pend3 | pend4;
	assign pend_early = pend2 | pend3;

	assign busy = pend_bit(pend_any, query_a) || pend_bit(pend_any, query_b);
	// only stage 4 left, its write lands at the coming edge
	assign clears_next = !pend_bit(pend_early, query_a) && !pend_bit(pend_early, query_b);

	assign flag_busy = flag2 | flag3;
	assign flag_clears_next = !flag2;	// stage 3 op already hit the ALU

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pend2 <= '0;
			pend3 <= '0;
			pend4 <= '0;
			flag2 <= 1'b0;
			flag3 <= 1'b0;
		end else begin
			pend2 <= mark_vec;
			pend3 <= pend2;
			pend4 <= pend3;
			flag2 <= mark_flags;
			flag3 <= flag2;
		end
	end

	a_mark_real_reg: assert property (@(posedge CLK) disable iff (!RSTb)
		mark_valid |-> mark_reg != reg_addr_t'(`CPU_NO_WRITE_ADDR));

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ns
`include "cpu16_config.svh"

module decode_stage (
	input  logic                 CLK,
	input  logic                 RSTb,
	input  cpu16_pkg::word_t     stage1_ins,
	input  logic                 flags_c,
	input  logic                 flags_z,
	input  logic                 flags_s,
	input  logic                 busy,
	input  logic                 clears_next,
	input  logic                 flag_busy,
	input  logic                 flag_clears_next,
	output cpu16_pkg::reg_addr_t reg_a_addr,
	output cpu16_pkg::reg_addr_t reg_b_addr,
	output cpu16_pkg::reg_addr_t query_a,
	output cpu16_pkg::reg_addr_t query_b,
	output cpu16_pkg::reg_addr_t mark_reg,
	output logic                 mark_valid,
	output logic                 mark_flags,
	output logic                 stall,
	output logic                 stall_rewind,
	output logic                 redirect,
	output cpu16_pkg::word_t     redirect_target,
	output cpu16_pkg::word_t     stage2_ins,
	output cpu16_pkg::word_t     stage2_imm
);
	import cpu16_pkg::*;

	localparam reg_addr_t NO_REG = reg_addr_t'(`CPU_NO_WRITE_ADDR);

	flags_t                      flags;
	logic [`CPU_IMM_HI_BITS-1:0] imm_hi;
	logic [`CPU_IMM_HI_BITS-1:0] imm_hi_next;
	word_t                       imm_full;
	logic                        writes_reg;
	logic                        is_prefix;
	logic                        is_branch;
	logic                        cond_branch;
	logic                        cond_met;
	logic                        flag_stall;

	assign flags = '{c: flags_c, z: flags_z, s: flags_s};
	assign imm_full = {imm_hi, ins_lo(stage1_ins)};

	// unused queries point at the no-write slot, which never pends
	always_comb begin
		reg_a_addr = '0;
		reg_b_addr = '0;
		query_a = NO_REG;
		query_b = NO_REG;
		mark_reg = NO_REG;
		writes_reg = 1'b0;
		is_prefix = 1'b0;
		is_branch = 1'b0;
		case (ins_class(stage1_ins))
			OPC_MISC: begin
				if (writes_src(stage1_ins)) begin
					reg_a_addr = ins_src(stage1_ins);
					query_a = ins_src(stage1_ins);
					mark_reg = ins_src(stage1_ins);
					writes_reg = 1'b1;
				end
			end
			OPC_IMM: is_prefix = 1'b1;
			OPC_ALU_RR: begin
				reg_a_addr = ins_dst(stage1_ins);
				reg_b_addr = ins_src(stage1_ins);
				query_a = ins_dst(stage1_ins);
				query_b = ins_src(stage1_ins);
				mark_reg = ins_dst(stage1_ins);
				writes_reg = 1'b1;
			end
			OPC_ALU_RI: begin
				reg_a_addr = ins_dst(stage1_ins);	// B gets the immediate
				query_a = ins_dst(stage1_ins);
				mark_reg = ins_dst(stage1_ins);
				writes_reg = 1'b1;
			end
			OPC_BRANCH: is_branch = 1'b1;
			default: ;
		endcase
	end

	always_comb begin
		cond_met = 1'b0;
		case (ins_cond(stage1_ins))
			COND_BZ:   cond_met = flags.z;
			COND_BNZ:  cond_met = !flags.z;
			COND_BS:   cond_met = flags.s;
			COND_BNS:  cond_met = !flags.s;
			COND_BC:   cond_met = flags.c;
			COND_BNC:  cond_met = !flags.c;
			COND_BA:   cond_met = 1'b1;
			COND_RSVD: cond_met = 1'b0;	// never taken
		endcase
	end

	// only branches that look at flags wait for them
	assign cond_branch = is_branch && ins_cond(stage1_ins) != COND_BA &&
		ins_cond(stage1_ins) != COND_RSVD;
	assign flag_stall = cond_branch && flag_busy;

	assign stall = busy || flag_stall;
	assign stall_rewind = (busy && !clears_next) || (flag_stall && !flag_clears_next);

	assign redirect = is_branch && cond_met && !stall;
	assign redirect_target = imm_full;

	assign mark_valid = writes_reg && !stall;
	assign mark_flags = is_alu_op(stage1_ins) && !stall;

	always_comb begin
		imm_hi_next = '0;	// prefix serves the next instruction only
		if (is_prefix)
			imm_hi_next = ins_imm_hi(stage1_ins);
		else if (stall)
			imm_hi_next = imm_hi;
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			imm_hi <= '0;
			stage2_ins <= NOP_INS;
		end else begin
			imm_hi <= imm_hi_next;
			stage2_ins <= stall ? NOP_INS : stage1_ins;	// bubble while stage 1 waits
		end
	end

	always_ff @(posedge CLK) begin
		stage2_imm <= imm_full;
	end

	a_no_stall_on_nop: assert property (@(posedge CLK) disable iff (!RSTb)
		stage1_ins == NOP_INS |-> !stall);

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ns
`include "cpu16_config.svh"

module execute_stage (
	input  logic                 CLK,
	input  logic                 RSTb,
	input  cpu16_pkg::word_t     stage2_ins,
	input  cpu16_pkg::word_t     stage2_imm,
	input  cpu16_pkg::word_t     reg_a,
	input  cpu16_pkg::word_t     reg_b,
	input  cpu16_pkg::word_t     alu_out,
	output cpu16_pkg::word_t     alu_a,
	output cpu16_pkg::word_t     alu_b,
	output cpu16_pkg::alu_op_t   alu_op,
	output cpu16_pkg::reg_addr_t reg_wr_addr,
	output cpu16_pkg::word_t     reg_file_in
);
	import cpu16_pkg::*;

	word_t stage3_ins;
	word_t stage4_ins;
	word_t result3;
	word_t result3_next;
	word_t result4;
	logic  stage3_alu;

	// stage 2 drives the ALU, inc and dec are done here
	always_comb begin
		alu_a = '0;
		alu_b = '0;
		alu_op = '0;
		result3_next = '0;
		case (ins_class(stage2_ins))
			OPC_MISC: begin
				case (ins_sub(stage2_ins))
					MISC_INC: result3_next = reg_a + word_t'(1);
					MISC_DEC: result3_next = reg_a - word_t'(1);
					MISC_ALU_SR: begin
						alu_b = reg_a;	// single-register ops use the B operand
						alu_op = alu_op_sr(stage2_ins);
					end
					default: ;
				endcase
			end
			OPC_ALU_RR: begin
				alu_a = reg_a;
				alu_b = reg_b;
				alu_op = alu_op_rr(stage2_ins);
			end
			OPC_ALU_RI: begin
				alu_a = reg_a;
				alu_b = stage2_imm;
				alu_op = alu_op_rr(stage2_ins);
			end
			default: ;
		endcase
	end

	assign stage3_alu = is_alu_op(stage3_ins);	// alu_out belongs to stage 3

	// stage 4 write-back
	always_comb begin
		reg_wr_addr = reg_addr_t'(`CPU_NO_WRITE_ADDR);
		reg_file_in = '0;
		if (writes_src(stage4_ins)) begin
			reg_wr_addr = ins_src(stage4_ins);
			reg_file_in = result4;
		end else if (ins_class(stage4_ins) inside {OPC_ALU_RR, OPC_ALU_RI}) begin
			reg_wr_addr = ins_dst(stage4_ins);
			reg_file_in = result4;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			stage3_ins <= NOP_INS;
			stage4_ins <= NOP_INS;
		end else begin
			stage3_ins <= stage2_ins;
			stage4_ins <= stage3_ins;
		end
	end

	always_ff @(posedge CLK) begin
		result3 <= result3_next;
		result4 <= stage3_alu ? alu_out : result3;
	end

	a_idle_alu_on_nop: assert property (@(posedge CLK) disable iff (!RSTb)
		stage2_ins == NOP_INS |-> alu_op == '0);

endmodule

// ==== source/pipeline16.sv ====
`timescale 1ns/1ns

// the register file returns read data one cycle after the address,
// the ALU registers its result and latches flags on the same edge
module pipeline16 (
	input  logic                 CLK,
	input  logic                 RSTb,
	input  logic                 C,
	input  logic                 Z,
	input  logic                 S,
	output cpu16_pkg::alu_op_t   alu_op,
	output cpu16_pkg::word_t     alu_a,
	output cpu16_pkg::word_t     alu_b,
	input  cpu16_pkg::word_t     alu_out,
	output cpu16_pkg::word_t     reg_file_in,
	output cpu16_pkg::reg_addr_t reg_wr_addr,
	output cpu16_pkg::reg_addr_t reg_a_addr,
	output cpu16_pkg::reg_addr_t reg_b_addr,
	input  cpu16_pkg::word_t     reg_a,
	input  cpu16_pkg::word_t     reg_b,
	input  cpu16_pkg::word_t     mem_in,
	output cpu16_pkg::word_t     memory_addr
);
	import cpu16_pkg::*;

	word_t     stage1_ins;
	word_t     stage2_ins;
	word_t     stage2_imm;
	word_t     redirect_target;
	logic      stall;
	logic      stall_rewind;
	logic      redirect;
	reg_addr_t query_a;
	reg_addr_t query_b;
	reg_addr_t mark_reg;
	logic      mark_valid;
	logic      mark_flags;
	logic      busy;
	logic      clears_next;
	logic      flag_busy;
	logic      flag_clears_next;

	fetch_unit u_fetch (
		.CLK             (CLK),
		.RSTb            (RSTb),
		.mem_in          (mem_in),
		.stall           (stall),
		.stall_rewind    (stall_rewind),
		.redirect        (redirect),
		.redirect_target (redirect_target),
		.memory_addr     (memory_addr),
		.stage1_ins      (stage1_ins)
	);

	hazard_scoreboard u_scoreboard (
		.CLK              (CLK),
		.RSTb             (RSTb),
		.mark_valid       (mark_valid),
		.mark_reg         (mark_reg),
		.mark_flags       (mark_flags),
		.query_a          (query_a),
		.query_b          (query_b),
		.busy             (busy),
		.clears_next      (clears_next),
		.flag_busy        (flag_busy),
		.flag_clears_next (flag_clears_next)
	);

	decode_stage u_decode (
		.CLK              (CLK),
		.RSTb             (RSTb),
		.stage1_ins       (stage1_ins),
		.flags_c          (C),
		.flags_z          (Z),
		.flags_s          (S),
		.busy             (busy),
		.clears_next      (clears_next),
		.flag_busy        (flag_busy),
		.flag_clears_next (flag_clears_next),
		.reg_a_addr       (reg_a_addr),
		.reg_b_addr       (reg_b_addr),
		.query_a          (query_a),
		.query_b          (query_b),
		.mark_reg         (mark_reg),
		.mark_valid       (mark_valid),
		.mark_flags       (mark_flags),
		.stall            (stall),
		.stall_rewind     (stall_rewind),
		.redirect         (redirect),
		.redirect_target  (redirect_target),
		.stage2_ins       (stage2_ins),
		.stage2_imm       (stage2_imm)
	);

	execute_stage u_execute (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.stage2_ins  (stage2_ins),
		.stage2_imm  (stage2_imm),
		.reg_a       (reg_a),
		.reg_b       (reg_b),
		.alu_out     (alu_out),
		.alu_a       (alu_a),
		.alu_b       (alu_b),
		.alu_op      (alu_op),
		.reg_wr_addr (reg_wr_addr),
		.reg_file_in (reg_file_in)
	);

endmodule

// ==== verif/tb_pipeline16.sv ====
`timescale 1ns/1ns
`include "cpu16_config.svh"

module tb_pipeline16;
	import cpu16_pkg::*;

	localparam int MEM_WORDS = 256;
	localparam int WAIT_LIMIT = 400;
	localparam reg_addr_t NO_REG = reg_addr_t'(`CPU_NO_WRITE_ADDR);
	localparam reg_addr_t NUM_REGS = reg_addr_t'(`CPU_NUM_REGS);

	logic      CLK = 1'b0;
	logic      RSTb;
	logic      C = 1'b0;
	logic      Z = 1'b0;
	logic      S = 1'b0;
	alu_op_t   alu_op;
	word_t     alu_a;
	word_t     alu_b;
	word_t     alu_out = '0;
	word_t     reg_file_in;
	reg_addr_t reg_wr_addr;
	reg_addr_t reg_a_addr;
	reg_addr_t reg_b_addr;
	word_t     reg_a = '0;
	word_t     reg_b = '0;
	word_t     mem_in = '0;
	word_t     memory_addr;

	word_t prog_mem [MEM_WORDS];
	word_t reg_mem [`CPU_NUM_REGS];

	// DUT outputs taken at the falling edge, the models apply them after the next rise
	alu_op_t     smp_op = '0;
	word_t       smp_a = '0;
	word_t       smp_b = '0;
	reg_addr_t   smp_ra = '0;
	reg_addr_t   smp_rb = '0;
	reg_addr_t   smp_wa = NO_REG;
	word_t       smp_wd = '0;
	logic [18:0] alu_res;

	reg_addr_t got_addr_q [$];
	word_t     got_data_q [$];
	reg_addr_t exp_addr_q [$];
	word_t     exp_data_q [$];

	// state of the instruction-set reference
	word_t ref_regs [`CPU_NUM_REGS];
	logic  ref_c;
	logic  ref_z;
	logic  ref_s;

	integer seed;

	pipeline16 u_pipeline16 (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.C           (C),
		.Z           (Z),
		.S           (S),
		.alu_op      (alu_op),
		.alu_a       (alu_a),
		.alu_b       (alu_b),
		.alu_out     (alu_out),
		.reg_file_in (reg_file_in),
		.reg_wr_addr (reg_wr_addr),
		.reg_a_addr  (reg_a_addr),
		.reg_b_addr  (reg_b_addr),
		.reg_a       (reg_a),
		.reg_b       (reg_b),
		.mem_in      (mem_in),
		.memory_addr (memory_addr)
	);

	always #20 CLK = ~CLK;

	// returns {C, Z, S, result}
	function automatic logic [18:0] alu_calc(input alu_op_t op, input word_t a, input word_t b);
		logic [16:0] wide;
		word_t       res;
		logic        carry;
		res = '0;
		carry = 1'b0;
		case (op)
			5'h00: begin
				wide = {1'b0, a} + {1'b0, b};
				res = wide[15:0];
				carry = wide[16];
			end
			5'h01: begin
				res = a - b;
				carry = a < b;	// borrow
			end
			5'h02: res = a & b;
			5'h10: begin
				res = {b[14:0], 1'b0};
				carry = b[15];
			end
			default: ;
		endcase
		alu_calc = {carry, res == '0, res[15], res};
	endfunction

	function automatic word_t read_reg(input reg_addr_t addr);
		read_reg = '0;
		if (addr < NUM_REGS)
			read_reg = reg_mem[addr[3:0]];
	endfunction

	task automatic stop_on_failure();
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	always @(negedge CLK) begin
		smp_op = alu_op;
		smp_a = alu_a;
		smp_b = alu_b;
		smp_ra = reg_a_addr;
		smp_rb = reg_b_addr;
		smp_wa = reg_wr_addr;
		smp_wd = reg_file_in;
		if (RSTb && reg_wr_addr != NO_REG) begin
			got_addr_q.push_back(reg_wr_addr);
			got_data_q.push_back(reg_file_in);
		end
		check_value("write address in range", 32'(reg_wr_addr <= NO_REG), 32'd1);
	end

	// register file, ALU and program memory
	always @(posedge CLK) begin
		#1;
		reg_a = read_reg(smp_ra);
		reg_b = read_reg(smp_rb);
		if (smp_wa < NUM_REGS)
			reg_mem[smp_wa[3:0]] = smp_wd;
		alu_res = alu_calc(smp_op, smp_a, smp_b);
		alu_out = alu_res[15:0];
		if (smp_op != '0)
			{C, Z, S} = alu_res[18:16];	// flags only move on a real op
		mem_in = prog_mem[memory_addr[7:0]];
	end

	task automatic ref_write(input logic [3:0] dst, input word_t val);
		ref_regs[dst] = val;
		exp_addr_q.push_back(reg_addr_t'(dst));
		exp_data_q.push_back(val);
	endtask

	task automatic ref_alu(input alu_op_t op, input word_t a, input word_t b,
		input logic [3:0] dst);
		logic [18:0] r;
		r = alu_calc(op, a, b);
		if (op != '0) begin
			ref_c = r[18];
			ref_z = r[17];
			ref_s = r[16];
		end
		ref_write(dst, r[15:0]);
	endtask

	// runs the program in order until n_writes register writes are known
	task automatic build_expected(input int n_writes);
		word_t       pc;
		word_t       ins;
		word_t       imm;
		logic [11:0] imm_hi;
		logic [11:0] hi_next;
		logic [3:0]  sub;
		logic [3:0]  dst;
		logic [3:0]  src;
		logic        taken;
		int          steps;
		pc = '0;
		imm_hi = '0;
		steps = 0;
		exp_addr_q.delete();
		exp_data_q.delete();
		while (exp_addr_q.size() < n_writes && steps < 2000) begin
			ins = prog_mem[pc[7:0]];
			pc = pc + 16'd1;
			sub = ins[11:8];
			dst = ins[7:4];
			src = ins[3:0];
			imm = {imm_hi, src};
			hi_next = '0;
			taken = 1'b0;
			case (ins[15:12])
				4'h0: begin
					if (sub == 4'h2)
						ref_write(src, ref_regs[src] + 16'd1);
					else if (sub == 4'h3)
						ref_write(src, ref_regs[src] - 16'd1);
					else if (sub == 4'h4)
						ref_alu({1'b1, dst}, '0, ref_regs[src], src);
				end
				4'h1: hi_next = ins[11:0];
				4'h2: ref_alu({1'b0, sub}, ref_regs[dst], ref_regs[src], dst);
				4'h3: ref_alu({1'b0, sub}, ref_regs[dst], imm, dst);
				4'h4: begin
					case (sub[2:0])
						3'd0: taken = ref_z;
						3'd1: taken = !ref_z;
						3'd2: taken = ref_s;
						3'd3: taken = !ref_s;
						3'd4: taken = ref_c;
						3'd5: taken = !ref_c;
						3'd6: taken = 1'b1;
						default: taken = 1'b0;
					endcase
					if (taken)
						pc = imm;
				end
				default: ;
			endcase
			imm_hi = hi_next;
			steps++;
		end
	endtask

	// reset goes low here, memories are loaded while it is held
	task automatic begin_reset();
		@(posedge CLK);
		#1 RSTb = 1'b0;
		for (int i = 0; i < 2; i++)
			@(posedge CLK);
		#1;
		for (int i = 0; i < MEM_WORDS; i++)
			prog_mem[i] = NOP_INS;
		for (int i = 0; i < `CPU_NUM_REGS; i++) begin
			reg_mem[i] = word_t'($random(seed));
			ref_regs[i] = reg_mem[i];
		end
		ref_c = C;
		ref_z = Z;
		ref_s = S;
		got_addr_q.delete();
		got_data_q.delete();
	endtask

	task automatic set_reg(input int idx, input word_t val);
		reg_mem[idx] = val;
		ref_regs[idx] = val;
	endtask

	task automatic end_reset();
		for (int i = 0; i < 14; i++)
			@(posedge CLK);
		#1 RSTb = 1'b1;
	endtask

	task automatic finish_test(input int n_writes, input string name);
		int cycles;
		build_expected(n_writes);
		cycles = 0;
		while (got_addr_q.size() < n_writes) begin
			@(posedge CLK);
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				$display("Timeout at %0t ns: %s test saw %0d of %0d register writes",
					$time, name, got_addr_q.size(), n_writes);
				stop_on_failure();
			end
		end
		for (int i = 0; i < 12; i++)
			@(posedge CLK);	// anything extra would show up here
		check_value({name, " write count"}, 32'(got_addr_q.size()), 32'(n_writes));
		for (int i = 0; i < n_writes; i++) begin
			check_value({name, " write address"}, 32'(got_addr_q[i]), 32'(exp_addr_q[i]));
			check_value({name, " write data"}, 32'(got_data_q[i]), 32'(exp_data_q[i]));
		end
	endtask

	task automatic test_reset_state();
		begin_reset();
		prog_mem[0] = 16'h2112;	// r1 -= r2
		prog_mem[1] = 16'h0203;	// inc r3
		end_reset();
		for (int i = 0; i < 2; i++) begin
			@(negedge CLK);
			check_value("idle write address", 32'(reg_wr_addr), 32'(NO_REG));
			check_value("idle alu_op", 32'(alu_op), 32'd0);
			check_value("idle alu_a", 32'(alu_a), 32'd0);
			check_value("idle alu_b", 32'(alu_b), 32'd0);
			check_value("fetch address", 32'(memory_addr), 32'(i));
		end
		finish_test(2, "reset");
	endtask

	task automatic test_imm_prefix();
		begin_reset();
		prog_mem[0] = 16'h1ABC;
		prog_mem[1] = 16'h3015;	// r1 += 0xabc5
		prog_mem[2] = 16'h3023;	// prefix used up, r2 += 3
		prog_mem[3] = 16'h1FF0;
		prog_mem[4] = 16'h321F;	// r1 &= 0xff0f, waits for r1
		end_reset();
		finish_test(3, "prefix");
	endtask

	task automatic test_hazards();
		begin_reset();
		prog_mem[0] = 16'h0201;
		prog_mem[1] = 16'h0201;
		prog_mem[2] = 16'h0302;
		prog_mem[3] = 16'h2012;	// r1 += r2
		prog_mem[4] = 16'h2113;	// r1 -= r3
		prog_mem[5] = 16'h2231;	// r3 &= r1
		prog_mem[6] = 16'h0203;
		end_reset();
		finish_test(7, "hazard");
	endtask

	task automatic test_branches();
		begin_reset();
		set_reg(3, 16'h00F0);
		set_reg(7, 16'h1234);
		set_reg(8, 16'h8000);
		prog_mem[8'h00] = 16'h2111;	// zero result
		prog_mem[8'h01] = 16'h4007;	// BZ 7, taken
		prog_mem[8'h02] = 16'h0202;
		prog_mem[8'h07] = 16'h0204;
		prog_mem[8'h08] = 16'h2155;
		prog_mem[8'h09] = 16'h410C;	// BNZ, not taken
		prog_mem[8'h0A] = 16'h0206;
		prog_mem[8'h0B] = 16'h2178;	// borrow sets C
		prog_mem[8'h0C] = 16'h440F;	// BC 15, taken
		prog_mem[8'h0D] = 16'h0209;
		prog_mem[8'h0F] = 16'h020A;
		prog_mem[8'h10] = 16'h1001;
		prog_mem[8'h11] = 16'h4604;	// BA 0x14
		prog_mem[8'h12] = 16'h020B;
		prog_mem[8'h14] = 16'h020C;
		prog_mem[8'h15] = 16'h2233;	// nonzero result
		prog_mem[8'h16] = 16'h4019;	// BZ, not taken
		prog_mem[8'h17] = 16'h020D;
		end_reset();
		finish_test(9, "branch");
	endtask

	task automatic test_single_reg();
		begin_reset();
		prog_mem[0] = 16'h0401;	// shift r1 left
		prog_mem[1] = 16'h0401;
		prog_mem[2] = 16'h0402;
		prog_mem[3] = 16'h2012;
		end_reset();
		finish_test(4, "single-register");
	endtask

	initial begin
		seed = 32'h4055_5209;
		RSTb = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++)
			prog_mem[i] = NOP_INS;
		for (int i = 0; i < `CPU_NUM_REGS; i++)
			reg_mem[i] = '0;
		test_reset_state();
		test_imm_prefix();
		test_hazards();
		test_branches();
		test_single_reg();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+include
source/cpu16_pkg.sv
source/fetch_unit.sv
source/hazard_scoreboard.sv
source/decode_stage.sv
source/execute_stage.sv
source/pipeline16.sv
verif/tb_pipeline16.sv

// ==== Makefile ====
TOP = tb_pipeline16

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -sv --assert -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
